// ==== verilog/wb8_pkg.sv ====
`default_nettype none

package wb8_pkg;

    // master request, held stable from stb until ack
    typedef struct packed {
        logic [31:0] adr;
        logic [7:0]  dat;
        logic        we;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_rsp_t;

    // 8 KiB of block RAM, aliased over the rest of the space
    localparam int RAM_ADDR_BITS = 13;

    localparam logic [31:0] LED_BASE   = 32'hFFFF_FFF0;
    localparam logic [31:0] TIMER_BASE = 32'hFFFF_FD00;
    localparam logic [31:0] PRNG_BASE  = 32'hFFFF_FE00;

    localparam int LED_WIN_BITS    = 4;
    localparam int PERIPH_WIN_BITS = 8;

    // timer register offsets
    localparam logic [2:0] TMR_CNT_LO = 3'd0;
    localparam logic [2:0] TMR_CNT_HI = 3'd1;
    localparam logic [2:0] TMR_CMP_LO = 3'd2;
    localparam logic [2:0] TMR_CMP_HI = 3'd3;
    localparam logic [2:0] TMR_CTRL   = 3'd4;

    localparam int TIMER_DIV = 4;

    localparam logic [31:0] PRNG_TAPS        = 32'h8020_0003;
    localparam logic [31:0] PRNG_RESET_STATE = 32'h0000_0001;

    localparam int RESET_HOLD = 16;

endpackage

`default_nettype wire

// ==== verilog/reset_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module reset_gen (
    input  wire  clk,
    input  wire  arst_n_i,
    input  wire  reset_req_i,
    output logic rst_o
);
    import wb8_pkg::*;

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    logic [CNT_W-1:0] hold_q;

    // rst_o is high exactly while hold_q is nonzero, computed one edge ahead
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q <= CNT_W'(RESET_HOLD);
            rst_o  <= 1'b1;
        end else if (reset_req_i) begin
            hold_q <= CNT_W'(RESET_HOLD);
            rst_o  <= 1'b1;
        end else begin
            if (hold_q != '0) begin
                hold_q <= hold_q - 1'b1;
            end
            rst_o <= (hold_q > CNT_W'(1));
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        reset_req_i |=> rst_o [*RESET_HOLD]);

endmodule

`default_nettype wire

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
    input  wire wb8_pkg::wb_req_t req_i,
    input  wire wb8_pkg::wb_rsp_t ram_rsp_i,
    input  wire wb8_pkg::wb_rsp_t led_rsp_i,
    input  wire wb8_pkg::wb_rsp_t tmr_rsp_i,
    input  wire wb8_pkg::wb_rsp_t prng_rsp_i,
    output wb8_pkg::wb_req_t      ram_req_o,
    output wb8_pkg::wb_req_t      led_req_o,
    output wb8_pkg::wb_req_t      tmr_req_o,
    output wb8_pkg::wb_req_t      prng_req_o,
    output wb8_pkg::wb_rsp_t      rsp_o
);
    import wb8_pkg::*;

    logic ram_hit;
    logic led_hit;
    logic tmr_hit;
    logic prng_hit;

    // 0xFFFFFFFx
    assign led_hit = (req_i.adr[31:LED_WIN_BITS] == LED_BASE[31:LED_WIN_BITS]);
    // 0xFFFFFDxx
    assign tmr_hit = (req_i.adr[31:PERIPH_WIN_BITS] == TIMER_BASE[31:PERIPH_WIN_BITS]);
    // 0xFFFFFExx
    assign prng_hit = (req_i.adr[31:PERIPH_WIN_BITS] == PRNG_BASE[31:PERIPH_WIN_BITS]);
    // everything else falls through to RAM
    assign ram_hit = ~(led_hit | tmr_hit | prng_hit);

    always_comb begin
        ram_req_o  = req_i;
        led_req_o  = req_i;
        tmr_req_o  = req_i;
        prng_req_o = req_i;

        // each strobe gated by its own window
        ram_req_o.stb  = req_i.stb & ram_hit;
        led_req_o.stb  = req_i.stb & led_hit;
        tmr_req_o.stb  = req_i.stb & tmr_hit;
        prng_req_o.stb = req_i.stb & prng_hit;

        if (led_hit) begin
            rsp_o = led_rsp_i;
        end else if (tmr_hit) begin
            rsp_o = tmr_rsp_i;
        end else if (prng_hit) begin
            rsp_o = prng_rsp_i;
        end else begin
            rsp_o = ram_rsp_i;
        end
    end

    always_comb begin
        a_one_stb: assert final ($onehot0({ram_req_o.stb, led_req_o.stb,
                                           tmr_req_o.stb, prng_req_o.stb}));
    end

endmodule

`default_nettype wire

// ==== verilog/bram_wb8.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram_wb8 (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t      rsp_o
);
    import wb8_pkg::*;

    logic [7:0]               mem [2**RAM_ADDR_BITS];
    logic [RAM_ADDR_BITS-1:0] addr;
    logic [7:0]               rdata_q;
    logic                     ack_q;
    logic                     take;

    assign addr = req_i.adr[RAM_ADDR_BITS-1:0];
    // first cycle of a strobe only
    assign take = req_i.stb & ~ack_q & ~rst_i;

    always_ff @(posedge clk) begin
        if (take && req_i.we) begin
            mem[addr] <= req_i.dat;
        end
        rdata_q <= mem[addr];
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

// ==== verilog/leds_wb8.sv ====
`timescale 1ns/10ps
`default_nettype none

module leds_wb8 (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t      rsp_o,
    output logic [7:0]            leds_o
);
    logic [7:0] leds_q;
    logic [7:0] rdata_q;
    logic       ack_q;
    logic       take;

    assign take = req_i.stb & ~ack_q;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= take;
            if (take && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    // readback of the value before any write in the same cycle
    always_ff @(posedge clk) begin
        if (take) begin
            rdata_q <= leds_q;
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;
    assign leds_o    = leds_q;

endmodule

`default_nettype wire

// ==== verilog/timer_wb8.sv ====
`timescale 1ns/10ps
`default_nettype none

module timer_wb8 (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t      rsp_o,
    output logic                  irq_o
);
    import wb8_pkg::*;

    localparam int PRE_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

    logic [PRE_W-1:0] presc_q;
    logic [15:0]      count_q;
    logic [15:0]      cmp_q;
    logic [7:0]       cnt_hi_q;
    logic [7:0]       rdata_q;
    logic             en_q;
    logic             pend_q;
    logic             en_d;
    logic             pend_d;
    logic             irq_q;
    logic             ack_q;
    logic             take;
    logic             wr;
    logic             tick;
    logic             clr_cnt;
    logic [2:0]       reg_sel;

    assign take    = req_i.stb & ~ack_q;
    assign wr      = take & req_i.we;
    assign reg_sel = req_i.adr[2:0];
    assign tick    = (presc_q == PRE_W'(TIMER_DIV - 1));
    assign clr_cnt = wr && (reg_sel == TMR_CMP_HI);

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            presc_q <= '0;
            count_q <= '0;
        end else if (clr_cnt) begin
            presc_q <= '0;
            count_q <= '0;
        end else if (tick) begin
            presc_q <= '0;
            count_q <= count_q + 16'd1;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    // a match on the last clock of a count value sets pending once
    always_comb begin
        en_d   = en_q;
        pend_d = pend_q;
        if (wr && reg_sel == TMR_CTRL) begin
            en_d = req_i.dat[0];
            if (req_i.dat[1]) begin
                pend_d = 1'b0;
            end
        end
        if (en_q && tick && count_q == cmp_q) begin
            pend_d = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            cmp_q    <= '1;
            cnt_hi_q <= '0;
            en_q     <= 1'b0;
            pend_q   <= 1'b0;
            irq_q    <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            ack_q  <= take;
            en_q   <= en_d;
            pend_q <= pend_d;
            irq_q  <= pend_d & en_d;
            if (wr && reg_sel == TMR_CMP_LO) begin
                cmp_q[7:0] <= req_i.dat;
            end
            if (clr_cnt) begin
                cmp_q[15:8] <= req_i.dat;
            end
            // reading the low byte freezes the high byte
            if (take && !req_i.we && reg_sel == TMR_CNT_LO) begin
                cnt_hi_q <= count_q[15:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (reg_sel)
                TMR_CNT_LO: rdata_q <= count_q[7:0];
                TMR_CNT_HI: rdata_q <= cnt_hi_q;
                TMR_CMP_LO: rdata_q <= cmp_q[7:0];
                TMR_CMP_HI: rdata_q <= cmp_q[15:8];
                TMR_CTRL:   rdata_q <= {6'd0, pend_q, en_q};
                default:    rdata_q <= '0;
            endcase
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;
    assign irq_o     = irq_q;

    a_irq_en: assert property (@(posedge clk) disable iff (rst_i)
        !en_q |-> !irq_o);

endmodule

`default_nettype wire

// ==== verilog/prng_wb8.sv ====
`timescale 1ns/10ps
`default_nettype none

module prng_wb8 (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t      rsp_o
);
    import wb8_pkg::*;

    logic [31:0] state_q;
    logic [7:0]  rdata_q;
    logic        ack_q;
    logic        take;
    logic        wr;
    logic [1:0]  byte_sel;

    // galois step, shift right and fold the taps back in
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = {1'b0, s[31:1]};
        if (s[0]) begin
            n = n ^ PRNG_TAPS;
        end
        return n;
    endfunction

    assign take     = req_i.stb & ~ack_q;
    assign wr       = take & req_i.we;
    assign byte_sel = req_i.adr[1:0];

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            state_q <= PRNG_RESET_STATE;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= take;
            if (wr) begin
                state_q[8*byte_sel +: 8] <= req_i.dat;
            end else if (take && byte_sel == 2'd0) begin
                state_q <= lfsr_step(state_q);
            end
        end
    end

    // value returned is the one before the step
    always_ff @(posedge clk) begin
        if (take) begin
            rdata_q <= state_q[8*byte_sel +: 8];
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

    a_no_lockup: assert property (@(posedge clk) disable iff (rst_i)
        (state_q != '0 && !wr) |=> state_q != '0);

endmodule

`default_nettype wire

// ==== verilog/periph_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  wire                   clk,
    input  wire                   arst_n_i,
    input  wire                   reset_req_i,
    input  wire wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t      rsp_o,
    output logic [7:0]            leds_o,
    output logic                  irq_o
);
    import wb8_pkg::*;

    logic    rst;
    wb_req_t ram_req;
    wb_req_t led_req;
    wb_req_t tmr_req;
    wb_req_t prng_req;
    wb_rsp_t ram_rsp;
    wb_rsp_t led_rsp;
    wb_rsp_t tmr_rsp;
    wb_rsp_t prng_rsp;

    reset_gen reset_gen_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reset_req_i (reset_req_i),
        .rst_o       (rst)
    );

    bus_decoder bus_decoder_i (
        .req_i      (req_i),
        .ram_rsp_i  (ram_rsp),
        .led_rsp_i  (led_rsp),
        .tmr_rsp_i  (tmr_rsp),
        .prng_rsp_i (prng_rsp),
        .ram_req_o  (ram_req),
        .led_req_o  (led_req),
        .tmr_req_o  (tmr_req),
        .prng_req_o (prng_req),
        .rsp_o      (rsp_o)
    );

    bram_wb8 bram_i (
        .clk   (clk),
        .rst_i (rst),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

    leds_wb8 leds_i (
        .clk    (clk),
        .rst_i  (rst),
        .req_i  (led_req),
        .rsp_o  (led_rsp),
        .leds_o (leds_o)
    );

    timer_wb8 timer_i (
        .clk   (clk),
        .rst_i (rst),
        .req_i (tmr_req),
        .rsp_o (tmr_rsp),
        .irq_o (irq_o)
    );

    prng_wb8 prng_i (
        .clk   (clk),
        .rst_i (rst),
        .req_i (prng_req),
        .rsp_o (prng_rsp)
    );

endmodule

`default_nettype wire

// ==== verification/tb_periph_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_periph_top;
    import wb8_pkg::*;

    localparam int ACK_TIMEOUT = 2 * RESET_HOLD + 8;
    localparam int RAM_OPS     = 200;
    localparam int PRNG_READS  = 50;

    logic        clk;
    logic        arst_n_i;
    logic        reset_req_i;
    wb_req_t     req;
    wb_rsp_t     rsp;
    logic [7:0]  leds;
    logic        irq;
    integer      seed;
    logic [7:0]  ram_model [2**RAM_ADDR_BITS];
    logic [31:0] prng_model;
    logic [7:0]  led_model;
    logic [RAM_ADDR_BITS-1:0] ram_written [$];

    periph_top dut_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .reset_req_i (reset_req_i),
        .req_i       (req),
        .rsp_o       (rsp),
        .leds_o      (leds),
        .irq_o       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
        if (exp !== act) begin
            stop_with_error($sformatf(
                "Mismatch at %0d ns: %s expected dat=%h ack=%b got dat=%h ack=%b",
                $time, name, exp.dat, exp.ack, act.dat, act.ack));
        end
    endtask

    task automatic check_leds(input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            stop_with_error($sformatf("Mismatch at %0d ns: leds_o expected %h got %h",
                $time, exp, act));
        end
    endtask

    task automatic check_irq(input logic exp, input logic act);
        if (exp !== act) begin
            stop_with_error($sformatf("Mismatch at %0d ns: irq_o expected %b got %b",
                $time, exp, act));
        end
    endtask

    task automatic check_count(input logic [15:0] min, input logic [15:0] act);
        if (act < min) begin
            stop_with_error($sformatf("Mismatch at %0d ns: timer count expected >= %0d got %0d",
                $time, min, act));
        end
    endtask

    function automatic wb_rsp_t ack_with(input logic [7:0] d);
        wb_rsp_t r;
        r.dat = d;
        r.ack = 1'b1;
        return r;
    endfunction

    // reference LFSR step: shift right, fold taps in when bit 0 falls out
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0] == 1'b1) begin
            n = n ^ PRNG_TAPS;
        end
        return n;
    endfunction

    // called 1 ns after a rising edge; returns there too
    task automatic bus_xfer(input logic [31:0] adr, input logic we, input logic [7:0] dat,
                            input bit in_reset, output wb_rsp_t got);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        req.adr = adr;
        req.we  = we;
        req.dat = dat;
        req.stb = 1'b1;
        while (!seen && n < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
            seen = rsp.ack;
            if (in_reset && seen && n <= RESET_HOLD) begin
                stop_with_error("The bus acknowledged a transfer while reset was still held.");
            end
        end
        if (!seen) begin
            stop_with_error($sformatf("No ack arrived within %0d cycles for address %h.",
                ACK_TIMEOUT, adr));
        end
        if (!in_reset && n != 1) begin
            stop_with_error($sformatf("Mismatch at %0d ns: ack latency expected 1 got %0d",
                $time, n));
        end
        got     = rsp;
        req.stb = 1'b0;
        req.we  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [7:0] dat);
        wb_rsp_t unused;
        bus_xfer(adr, 1'b1, dat, 1'b0, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output wb_rsp_t got);
        bus_xfer(adr, 1'b0, 8'h00, 1'b0, got);
    endtask

    initial begin
        wb_rsp_t     got;
        int          i;
        int          n;
        int          c;
        int          idx;
        logic [31:0] adr;
        logic [31:0] s;
        logic [7:0]  d;
        logic [15:0] cnt;

        seed        = 83559;
        arst_n_i    = 1'b0;
        reset_req_i = 1'b0;
        req         = '0;
        repeat (10) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        led_model = 8'h00;

        // first transfer is issued while the internal reset is held
        bus_xfer(LED_BASE, 1'b0, 8'h00, 1'b1, got);
        check_rsp("rsp_o", ack_with(led_model), got);
        check_leds(led_model, leds);
        check_irq(1'b0, irq);

        for (i = 0; i < RAM_OPS; i++) begin
            adr = $random(seed);
            // keep clear of the peripheral windows
            if (adr[31:16] == 16'hFFFF) begin
                adr[31] = 1'b0;
            end
            if (ram_written.size() == 0 || ($random(seed) & 1)) begin
                d = $random(seed);
                bus_write(adr, d);
                ram_model[adr[RAM_ADDR_BITS-1:0]] = d;
                ram_written.push_back(adr[RAM_ADDR_BITS-1:0]);
            end else begin
                idx = $unsigned($random(seed)) % ram_written.size();
                adr[RAM_ADDR_BITS-1:0] = ram_written[idx];
                bus_read(adr, got);
                check_rsp("rsp_o", ack_with(ram_model[adr[RAM_ADDR_BITS-1:0]]), got);
            end
        end

        for (i = 0; i < 10; i++) begin
            d = $random(seed);
            bus_write(LED_BASE | ($random(seed) & 32'hF), d);
            led_model = d;
            check_leds(led_model, leds);
            bus_read(LED_BASE | ($random(seed) & 32'hF), got);
            check_rsp("rsp_o", ack_with(led_model), got);
        end

        reset_req_i = 1'b1;
        @(posedge clk);
        #1;
        reset_req_i = 1'b0;
        led_model   = 8'h00;
        prng_model  = PRNG_RESET_STATE;
        check_leds(led_model, leds);
        bus_xfer(LED_BASE, 1'b0, 8'h00, 1'b1, got);
        check_rsp("rsp_o", ack_with(led_model), got);

        // LFSR restarts from its reset state
        bus_read(PRNG_BASE, got);
        check_rsp("rsp_o", ack_with(prng_model[7:0]), got);
        prng_model = next_lfsr(prng_model);

        s = $random(seed);
        if (s == 32'h0) begin
            s = 32'h1;
        end
        for (i = 0; i < 4; i++) begin
            bus_write(PRNG_BASE + i, s[8*i +: 8]);
        end
        prng_model = s;
        for (i = 0; i < PRNG_READS; i++) begin
            bus_read(PRNG_BASE, got);
            check_rsp("rsp_o", ack_with(prng_model[7:0]), got);
            prng_model = next_lfsr(prng_model);
        end
        for (i = 1; i < 4; i++) begin
            bus_read(PRNG_BASE + i, got);
            check_rsp("rsp_o", ack_with(prng_model[8*i +: 8]), got);
        end
        bus_read(PRNG_BASE, got);
        check_rsp("rsp_o", ack_with(prng_model[7:0]), got);
        prng_model = next_lfsr(prng_model);

        c = 8 + ($unsigned($random(seed)) % 33);
        bus_write(TIMER_BASE + TMR_CMP_LO, c[7:0]);
        bus_write(TIMER_BASE + TMR_CMP_HI, 8'h00);
        bus_write(TIMER_BASE + TMR_CTRL, 8'h01);
        n = 0;
        while (!irq && n < (c + 2) * TIMER_DIV) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!irq) begin
            stop_with_error("The timer interrupt did not rise before the compare timeout.");
        end
        bus_read(TIMER_BASE + TMR_CNT_LO, got);
        cnt[7:0] = got.dat;
        bus_read(TIMER_BASE + TMR_CNT_HI, got);
        cnt[15:8] = got.dat;
        check_count(c[15:0], cnt);
        bus_read(TIMER_BASE + TMR_CTRL, got);
        check_rsp("rsp_o", ack_with(8'h03), got);
        bus_write(TIMER_BASE + TMR_CTRL, 8'h03);
        check_irq(1'b0, irq);

        // disabled: same interval must pass without an interrupt
        bus_write(TIMER_BASE + TMR_CTRL, 8'h02);
        bus_write(TIMER_BASE + TMR_CMP_HI, 8'h00);
        for (i = 0; i < (c + 2) * TIMER_DIV; i++) begin
            @(posedge clk);
            #1;
            check_irq(1'b0, irq);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/wb8_pkg.sv
verilog/reset_gen.sv
verilog/bus_decoder.sv
verilog/bram_wb8.sv
verilog/leds_wb8.sv
verilog/timer_wb8.sv
verilog/prng_wb8.sv
verilog/periph_top.sv
verification/tb_periph_top.sv
